/* hw/rtr_input_ctrl.sv */
// Router input controller
`timescale 1ns/1ps
`default_nettype none

module rtr_input_ctrl
   import rtr_pkg::*;
#(
   parameter int BUFFER_DEPTH = 4
)
(
   input  wire                clk,
   input  wire                rst_n,
   input  wire  [COORD_W-1:0] router_x,
   input  wire  [COORD_W-1:0] router_y,
   input  wire                in_valid,
   input  wire  [FLIT_W-1:0]  in_flit,
   output logic               credit_out,
   rtr_req_if.input_side      req
);

   // pointer wraps naturally since depth is a power of two
   localparam int PTR_W = $clog2(BUFFER_DEPTH);
   // count has to reach BUFFER_DEPTH itself
   localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

   logic [FLIT_W-1:0]  buf_mem [BUFFER_DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [CNT_W-1:0]   count;
   logic               empty;
   logic               full;
   logic               push;
   logic               pop;
   logic [FLIT_W-1:0]  head_flit;
   logic [COORD_W-1:0] dest_x;
   logic [COORD_W-1:0] dest_y;
   logic [NUM_PORTS-1:0] route;

   // ------------------------------
   // flit buffer
   // ------------------------------

   assign empty = (count == '0);
   assign full  = (count == CNT_W'(BUFFER_DEPTH));

   // writes into a full buffer are dropped
   // upstream credit keeps this from happening
   assign push = in_valid && !full;
   // head leaves when the allocator grants it
   assign pop  = req.req && req.gnt;

   // flit storage
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         buf_mem[wr_ptr] <= in_flit;
      end
   end

   // pointers and occupancy
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign head_flit = buf_mem[rd_ptr];

   // ------------------------------
   // XY route of the head flit
   // ------------------------------

   assign dest_x = head_flit[DEST_X_LSB +: COORD_W];
   assign dest_y = head_flit[DEST_Y_LSB +: COORD_W];

   // resolve x first, y only once x matches
   always_comb
   begin
      route = '0;
      if (dest_x > router_x)
         route[PORT_EAST] = 1'b1;
      else if (dest_x < router_x)
         route[PORT_WEST] = 1'b1;
      else if (dest_y > router_y)
         route[PORT_NORTH] = 1'b1;
      else if (dest_y < router_y)
         route[PORT_SOUTH] = 1'b1;
      else
         route[PORT_LOCAL] = 1'b1;
   end

   // request stays up as long as something is buffered
   assign req.req      = !empty;
   assign req.req_port = route;
   assign req.flit     = head_flit;

   // ------------------------------
   // credit return
   // ------------------------------

   // one pulse per popped flit, a cycle after the pop
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         credit_out <= 1'b0;
      else
         credit_out <= pop;
   end

endmodule

`default_nettype wire

/* hw/rtr_output_ctrl.sv */
// Router output controller
`timescale 1ns/1ps
`default_nettype none

module rtr_output_ctrl
   import rtr_pkg::*;
#(
   parameter int BUFFER_DEPTH = 4
)
(
   input  wire                                  clk,
   input  wire                                  rst_n,
   input  wire  [NUM_PORTS-1:0][FLIT_W-1:0]     in_flits,
   input  wire  [NUM_PORTS-1:0][NUM_PORTS-1:0]  xbar_sel,
   input  wire  [NUM_PORTS-1:0]                 xbar_valid,
   input  wire  [NUM_PORTS-1:0]                 credit_in,
   output logic [NUM_PORTS-1:0]                 credit_avail,
   output logic [NUM_PORTS-1:0]                 out_valid,
   output logic [NUM_PORTS-1:0][FLIT_W-1:0]     out_flit
);

   // counter spans 0..BUFFER_DEPTH inclusive
   localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

   // ------------------------------
   // crossbar
   // ------------------------------

   // AND-OR mux, select is one-hot or all zero
   logic [NUM_PORTS-1:0][FLIT_W-1:0] xbar_out;

   always_comb
   begin
      for (int o = 0; o < NUM_PORTS; o++)
      begin
         xbar_out[o] = '0;
         for (int i = 0; i < NUM_PORTS; i++)
         begin
            xbar_out[o] = xbar_out[o] | ({FLIT_W{xbar_sel[o][i]}} & in_flits[i]);
         end
      end
   end

   // ------------------------------
   // per output port
   // ------------------------------

   for (genvar o = 0; o < NUM_PORTS; o++)
   begin : g_out

      // free slots in the downstream input buffer
      logic [CNT_W-1:0] credit_cnt;

      // valid strobe for the link
      always_ff @(posedge clk or negedge rst_n)
      begin
         if (!rst_n)
            out_valid[o] <= 1'b0;
         else
            out_valid[o] <= xbar_valid[o];
      end

      // data only loads on a traversal, stale otherwise
      always_ff @(posedge clk)
      begin
         if (xbar_valid[o])
         begin
            out_flit[o] <= xbar_out[o];
         end
      end

      // a grant spends a credit, a returned pulse refunds one
      // both at once leave the count unchanged
      always_ff @(posedge clk or negedge rst_n)
      begin
         if (!rst_n)
         begin
            credit_cnt <= CNT_W'(BUFFER_DEPTH);
         end
         else
         begin
            case ({xbar_valid[o], credit_in[o]})
               2'b10:   credit_cnt <= credit_cnt - 1'b1;
               2'b01:   credit_cnt <= credit_cnt + 1'b1;
               default: credit_cnt <= credit_cnt;
            endcase
         end
      end

      // allocator masks requests with this
      assign credit_avail[o] = (credit_cnt != '0);

   end

endmodule

`default_nettype wire

/* hw/rtr_pkg.sv */
// Mesh router shared constants
`default_nettype none

package rtr_pkg;

   // ------------------------------
   // port numbering
   // ------------------------------

   // five ports, local plus four mesh neighbors
   localparam int NUM_PORTS = 5;

   localparam int PORT_LOCAL = 0;
   localparam int PORT_EAST  = 1;
   localparam int PORT_WEST  = 2;
   localparam int PORT_NORTH = 3;
   localparam int PORT_SOUTH = 4;

   // enough bits to hold any port index 0..4
   localparam int PORT_IDX_W = 3;

   // ------------------------------
   // flit layout
   // ------------------------------

   // one mesh coordinate, 4 routers per dimension
   localparam int COORD_W = 2;

   // payload sits in the low bits
   localparam int PAYLOAD_W = 12;

   // destination y right above the payload, destination x on top
   localparam int DEST_Y_LSB = PAYLOAD_W;
   localparam int DEST_X_LSB = DEST_Y_LSB + COORD_W;

   // whole flit, 16 bits
   localparam int FLIT_W = PAYLOAD_W + 2 * COORD_W;

endpackage

`default_nettype wire

/* hw/rtr_req_if.sv */
// Switch request channel
`timescale 1ns/1ps
`default_nettype none

interface rtr_req_if
   import rtr_pkg::*;
   ();

   // buffer non-empty, head flit wants an output
   logic                 req;

   // one-hot output port chosen by the route computation
   logic [NUM_PORTS-1:0] req_port;

   // head flit of the input buffer, goes to the crossbar
   logic [FLIT_W-1:0]    flit;

   // switch grant, combinational in the request cycle
   logic                 gnt;

   // input controller drives the request and sees the grant
   modport input_side (
      output req,
      output req_port,
      output flit,
      input  gnt
   );

   // allocator only needs the request, the flit bypasses it
   modport alloc_side (
      input  req,
      input  req_port,
      output gnt
   );

endinterface

`default_nettype wire

/* hw/rtr_sw_alloc.sv */
// Router switch allocator
`timescale 1ns/1ps
`default_nettype none

module rtr_sw_alloc
   import rtr_pkg::*;
(
   input  wire                                  clk,
   input  wire                                  rst_n,
   rtr_req_if.alloc_side                        req [NUM_PORTS],
   input  wire  [NUM_PORTS-1:0]                 credit_avail,
   output logic [NUM_PORTS-1:0][NUM_PORTS-1:0]  xbar_sel,
   output logic [NUM_PORTS-1:0]                 xbar_valid
);

   // per input: valid and one-hot wanted output, indexed [input][output]
   logic [NUM_PORTS-1:0]                 req_vld;
   logic [NUM_PORTS-1:0][NUM_PORTS-1:0]  req_dir;
   // per output: inputs eligible for it, indexed [output][input]
   logic [NUM_PORTS-1:0][NUM_PORTS-1:0]  cand;
   // per output: winning input, one-hot and as an index
   logic [NUM_PORTS-1:0][NUM_PORTS-1:0]  win;
   logic [NUM_PORTS-1:0][PORT_IDX_W-1:0] win_idx;
   // per output round-robin priority pointer
   logic [NUM_PORTS-1:0][PORT_IDX_W-1:0] rr_ptr;
   // per input grant
   logic [NUM_PORTS-1:0]                 gnt;

   // ------------------------------
   // interface unpacking
   // ------------------------------

   // request channels gathered into per-port vectors
   for (genvar i = 0; i < NUM_PORTS; i++)
   begin : g_in
      assign req_vld[i] = req[i].req;
      assign req_dir[i] = req[i].req_port;
      assign req[i].gnt = gnt[i];
   end

   // ------------------------------
   // candidates and arbitration
   // ------------------------------

   // an output with no credit left sees no requests at all
   always_comb
   begin
      for (int o = 0; o < NUM_PORTS; o++)
      begin
         for (int i = 0; i < NUM_PORTS; i++)
         begin
            cand[o][i] = req_vld[i] && req_dir[i][o] && credit_avail[o];
         end
      end
   end

   // search from the pointer upward, wrapping past the last port
   always_comb
   begin
      int  idx;
      logic found;
      for (int o = 0; o < NUM_PORTS; o++)
      begin
         win[o]     = '0;
         win_idx[o] = '0;
         found      = 1'b0;
         for (int k = 0; k < NUM_PORTS; k++)
         begin
            idx = int'(rr_ptr[o]) + k;
            if (idx >= NUM_PORTS)
               idx = idx - NUM_PORTS;
            if (!found && cand[o][idx])
            begin
               win[o][idx] = 1'b1;
               win_idx[o]  = PORT_IDX_W'(idx);
               found       = 1'b1;
            end
         end
      end
   end

   assign xbar_sel = win;

   // output busy this cycle when any input won it
   always_comb
   begin
      for (int o = 0; o < NUM_PORTS; o++)
      begin
         xbar_valid[o] = |win[o];
      end
   end

   // each input asks for one output only, so at most one bit here is set
   always_comb
   begin
      gnt = '0;
      for (int o = 0; o < NUM_PORTS; o++)
      begin
         gnt = gnt | win[o];
      end
   end

   // ------------------------------
   // priority pointers
   // ------------------------------

   // winner drops to lowest priority after a grant
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rr_ptr <= '0;
      end
      else
      begin
         for (int o = 0; o < NUM_PORTS; o++)
         begin
            if (xbar_valid[o])
            begin
               if (win_idx[o] == PORT_IDX_W'(NUM_PORTS - 1))
                  rr_ptr[o] <= '0;
               else
                  rr_ptr[o] <= win_idx[o] + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* hw/rtr_top.sv */
// Five-port mesh router
`timescale 1ns/1ps
`default_nettype none

module rtr_top
   import rtr_pkg::*;
#(
   parameter int BUFFER_DEPTH = 4
)
(
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire  [COORD_W-1:0]                router_x,
   input  wire  [COORD_W-1:0]                router_y,
   input  wire  [NUM_PORTS-1:0]              in_valid,
   input  wire  [NUM_PORTS-1:0][FLIT_W-1:0]  in_flit,
   output wire  [NUM_PORTS-1:0]              credit_out,
   output wire  [NUM_PORTS-1:0]              out_valid,
   output wire  [NUM_PORTS-1:0][FLIT_W-1:0]  out_flit,
   input  wire  [NUM_PORTS-1:0]              credit_in
);

   // one request channel per input port
   rtr_req_if req_if [NUM_PORTS] ();

   // buffer heads into the crossbar
   logic [NUM_PORTS-1:0][FLIT_W-1:0]    head_flits;
   // allocator to output side
   logic [NUM_PORTS-1:0][NUM_PORTS-1:0] xbar_sel;
   logic [NUM_PORTS-1:0]                xbar_valid;
   // output side back to the allocator
   logic [NUM_PORTS-1:0]                credit_avail;

   // ------------------------------
   // input controllers
   // ------------------------------

   for (genvar ip = 0; ip < NUM_PORTS; ip++)
   begin : g_ip
      rtr_input_ctrl #(
         .BUFFER_DEPTH (BUFFER_DEPTH)
      ) ipc (
         .clk        (clk),
         .rst_n      (rst_n),
         .router_x   (router_x),
         .router_y   (router_y),
         .in_valid   (in_valid[ip]),
         .in_flit    (in_flit[ip]),
         .credit_out (credit_out[ip]),
         .req        (req_if[ip])
      );

      assign head_flits[ip] = req_if[ip].flit;
   end

   // ------------------------------
   // allocator and output side
   // ------------------------------

   rtr_sw_alloc alo (
      .clk          (clk),
      .rst_n        (rst_n),
      .req          (req_if),
      .credit_avail (credit_avail),
      .xbar_sel     (xbar_sel),
      .xbar_valid   (xbar_valid)
   );

   rtr_output_ctrl #(
      .BUFFER_DEPTH (BUFFER_DEPTH)
   ) opc (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_flits     (head_flits),
      .xbar_sel     (xbar_sel),
      .xbar_valid   (xbar_valid),
      .credit_in    (credit_in),
      .credit_avail (credit_avail),
      .out_valid    (out_valid),
      .out_flit     (out_flit)
   );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Compile the mesh router testbench with Verilator and run it.
# The exit status is the simulator's own, nonzero on any $fatal.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=tb_rtr_top

verilator --binary --timing -j 0 \
   -f src.f \
   --top-module "$TOP" \
   -Mdir "$BUILD_DIR"
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit "$status"
fi

"./$BUILD_DIR/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation ended with status $status"
   exit "$status"
fi

echo "simulation ended normally"
exit 0

/* src.f */
+incdir+test
hw/rtr_pkg.sv
hw/rtr_req_if.sv
hw/rtr_input_ctrl.sv
hw/rtr_sw_alloc.sv
hw/rtr_output_ctrl.sv
hw/rtr_top.sv
test/tb_rtr_top.sv

/* test/tb_rtr_vectors.svh */
// Router routing vectors
// columns: input port, dest x, dest y, payload, expected output port
// ports 0 local, 1 east, 2 west, 3 north, 4 south; router sits at (1,1)

localparam int NUM_VEC = 16;

localparam vec_t VEC_TABLE [NUM_VEC] = '{
   // local input, one flit to each neighbor
   {3'd0, 2'd2, 2'd1, 12'h011, 3'd1},
   {3'd0, 2'd0, 2'd3, 12'h012, 3'd2},   // x wins over y
   {3'd0, 2'd1, 2'd3, 12'h013, 3'd3},
   {3'd0, 2'd1, 2'd0, 12'h014, 3'd4},
   // east input
   {3'd1, 2'd1, 2'd1, 12'h021, 3'd0},
   {3'd1, 2'd0, 2'd0, 12'h022, 3'd2},
   {3'd1, 2'd1, 2'd0, 12'h023, 3'd4},
   // west input
   {3'd2, 2'd3, 2'd0, 12'h031, 3'd1},
   {3'd2, 2'd1, 2'd2, 12'h032, 3'd3},
   {3'd2, 2'd1, 2'd1, 12'h033, 3'd0},
   // north input
   {3'd3, 2'd1, 2'd0, 12'h041, 3'd4},
   {3'd3, 2'd2, 2'd3, 12'h042, 3'd1},
   {3'd3, 2'd3, 2'd3, 12'h043, 3'd1},
   // south input
   {3'd4, 2'd1, 2'd1, 12'h051, 3'd0},
   {3'd4, 2'd0, 2'd2, 12'h052, 3'd2},
   {3'd4, 2'd1, 2'd3, 12'h053, 3'd3}
};

/* test/tb_rtr_top.sv */
// Mesh router testbench
`timescale 1ns/1ps
`default_nettype none

module tb_rtr_top
   import rtr_pkg::*;
();

   localparam int BUFFER_DEPTH = 4;
   localparam int CLK_PERIOD   = 20;

   // one row of the routing table
   typedef struct packed {
      logic [PORT_IDX_W-1:0] in_port;
      logic [COORD_W-1:0]    dest_x;
      logic [COORD_W-1:0]    dest_y;
      logic [PAYLOAD_W-1:0]  payload;
      logic [PORT_IDX_W-1:0] out_port;
   } vec_t;

   `include "tb_rtr_vectors.svh"

   logic                             clk;
   logic                             rst_n;
   logic [COORD_W-1:0]               router_x;
   logic [COORD_W-1:0]               router_y;
   logic [NUM_PORTS-1:0]             in_valid  = '0;
   logic [NUM_PORTS-1:0][FLIT_W-1:0] in_flit   = '0;
   logic [NUM_PORTS-1:0]             credit_in = '0;
   wire  [NUM_PORTS-1:0]             credit_out;
   wire  [NUM_PORTS-1:0]             out_valid;
   wire  [NUM_PORTS-1:0][FLIT_W-1:0] out_flit;

   // flits waiting to be sent, per input
   logic [FLIT_W-1:0] tx_q [NUM_PORTS][$];
   // expected arrivals, indexed input * NUM_PORTS + output
   logic [FLIT_W-1:0] exp_q [NUM_PORTS*NUM_PORTS][$];

   // upstream side of each input link
   int up_used [NUM_PORTS];
   int sent_cnt [NUM_PORTS];
   int cred_cnt [NUM_PORTS];
   // downstream side of each output link
   int rx_cnt [NUM_PORTS];
   int owed [NUM_PORTS];
   int rel_used [NUM_PORTS];
   int rel_cnt [NUM_PORTS];
   logic [NUM_PORTS-1:0] hold = '0;

   // lone flit bookkeeping for the latency check
   bit                lone_mode = 1'b0;
   int                lone_port;
   logic [FLIT_W-1:0] lone_flit;
   int                sent_cyc;
   int                cyc;
   int                seed;

   rtr_top #(
      .BUFFER_DEPTH (BUFFER_DEPTH)
   ) rtr_top_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .router_x   (router_x),
      .router_y   (router_y),
      .in_valid   (in_valid),
      .in_flit    (in_flit),
      .credit_out (credit_out),
      .out_valid  (out_valid),
      .out_flit   (out_flit),
      .credit_in  (credit_in)
   );

   // ------------------------------
   // clock and watchdog
   // ------------------------------

   initial
   begin
      clk = 1'b0;
      forever
         #(CLK_PERIOD / 2) clk = ~clk;
   end

   // budget grows with the table, plus room for the stall and burst phases
   initial
   begin
      #((NUM_VEC * 20 + 200) * CLK_PERIOD);
      abort_run("timeout, the router did not deliver all flits and credits in time");
   end

   // ------------------------------
   // helpers
   // ------------------------------

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   // dest x on top, dest y below it, payload in the low bits
   task automatic queue_flit(input int src, input int dx, input int dy,
                             input int payload, input int dst);
      logic [FLIT_W-1:0] flit;
      flit = {dx[COORD_W-1:0], dy[COORD_W-1:0], payload[PAYLOAD_W-1:0]};
      tx_q[src].push_back(flit);
      exp_q[src*NUM_PORTS+dst].push_back(flit);
   endtask

   // all queued flits delivered and unheld credits handed back
   task automatic wait_drained();
      int pending;
      pending = 1;
      while (pending != 0)
      begin
         @(posedge clk);
         pending = 0;
         for (int i = 0; i < NUM_PORTS; i++)
         begin
            pending += tx_q[i].size();
            if (!hold[i])
               pending += owed[i];
         end
         for (int k = 0; k < NUM_PORTS * NUM_PORTS; k++)
            pending += exp_q[k].size();
      end
   endtask

   task automatic wait_count(input int port, input int target);
      while (rx_cnt[port] < target)
      begin
         @(posedge clk);
      end
   endtask

   // ------------------------------
   // link model on the falling edge
   // ------------------------------

   // monitors first, then the drivers, all in one process
   always @(negedge clk)
   begin : link_model
      int hit;
      cyc = cyc + 1;

      for (int o = 0; o < NUM_PORTS; o++)
      begin
         if (out_valid[o] === 1'b1)
         begin
            if (lone_mode)
            begin
               check("routed output port", o, lone_port);
               check("out_flit", 32'(out_flit[o]), 32'(lone_flit));
               check("latency in cycles", cyc - sent_cyc, 2);
            end
            // arrival must be the oldest pending flit of some input
            hit = -1;
            for (int i = 0; i < NUM_PORTS; i++)
            begin
               if (hit < 0 && exp_q[i*NUM_PORTS+o].size() > 0)
               begin
                  if (exp_q[i*NUM_PORTS+o][0] == out_flit[o])
                     hit = i;
               end
            end
            if (hit < 0)
               abort_run($sformatf("output %0d delivered flit %h that no input expected next",
                                   o, out_flit[o]));
            else
            begin
               void'(exp_q[hit*NUM_PORTS+o].pop_front());
               rx_cnt[o]++;
               owed[o]++;
            end
         end
      end

      // credits coming back from the input buffers
      for (int i = 0; i < NUM_PORTS; i++)
      begin
         if (credit_out[i] === 1'b1)
         begin
            cred_cnt[i]++;
            up_used[i]--;
         end
      end

      // send only while the input buffer has room
      in_valid = '0;
      for (int i = 0; i < NUM_PORTS; i++)
      begin
         if (tx_q[i].size() > 0 && up_used[i] < BUFFER_DEPTH)
         begin
            in_valid[i] = 1'b1;
            in_flit[i]  = tx_q[i].pop_front();
            up_used[i]++;
            sent_cnt[i]++;
            sent_cyc = cyc;
         end
      end

      // downstream hands credits back at once unless held
      credit_in = '0;
      for (int o = 0; o < NUM_PORTS; o++)
      begin
         if (owed[o] > 0 && (!hold[o] || rel_used[o] < rel_cnt[o]))
         begin
            credit_in[o] = 1'b1;
            owed[o]--;
            if (hold[o])
               rel_used[o]++;
         end
      end
   end

   // ------------------------------
   // test sequence
   // ------------------------------

   initial
   begin : stimulus
      vec_t v;
      int   base;
      rst_n    = 1'b0;
      router_x = 2'd1;
      router_y = 2'd1;
      seed     = 21549;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      // idle router returns no credits
      repeat (3) @(posedge clk);
      for (int i = 0; i < NUM_PORTS; i++)
         check($sformatf("credit_out[%0d] after reset", i), cred_cnt[i], 0);

      // routing, latency and payload, one flit at a time
      lone_mode = 1'b1;
      for (int r = 0; r < NUM_VEC; r++)
      begin
         v         = VEC_TABLE[r];
         lone_port = int'(v.out_port);
         lone_flit = {v.dest_x, v.dest_y, v.payload};
         queue_flit(int'(v.in_port), int'(v.dest_x), int'(v.dest_y),
                    int'(v.payload), int'(v.out_port));
         wait_drained();
      end
      lone_mode = 1'b0;

      // east stalled, 6 flits from two inputs, only 4 credits
      base             = rx_cnt[PORT_EAST];
      hold[PORT_EAST]  = 1'b1;
      for (int k = 0; k < 3; k++)
      begin
         queue_flit(PORT_LOCAL, 2, 0, 'h600 + k, PORT_EAST);
         queue_flit(PORT_NORTH, 3, 2, 'h610 + k, PORT_EAST);
      end
      wait_count(PORT_EAST, base + 4);
      repeat (10) @(posedge clk);
      check("east flits while stalled", rx_cnt[PORT_EAST], base + 4);
      rel_cnt[PORT_EAST] = 2;
      wait_drained();
      hold[PORT_EAST] = 1'b0;
      wait_drained();

      // four inputs burst into local together
      // the input tag keeps payloads unique
      for (int k = 0; k < 6; k++)
      begin
         for (int i = PORT_EAST; i <= PORT_SOUTH; i++)
            queue_flit(i, 1, 1, 'h800 | (i << 8) | ($random(seed) & 'hff), PORT_LOCAL);
      end
      wait_drained();

      // exactly one credit per accepted flit
      for (int i = 0; i < NUM_PORTS; i++)
         check($sformatf("credit_out[%0d] pulses", i), cred_cnt[i], sent_cnt[i]);

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire
